/* Makefile */
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale 1ns/1ns --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dcache_top.f */
+incdir+rtl
rtl/cache_geom_pkg.sv
rtl/mem_bus_pkg.sv
rtl/set_array.sv
rtl/tag_lookup.sv
rtl/lru_tracker.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
sim/tb_clock.sv
sim/dcache_tb.sv

/* rtl/cache_geom_pkg.sv */
`default_nettype none
`include "dcache_cfg.svh"

// cache organisation and cpu address fields
package cache_geom_pkg;

  typedef logic [`DC_ADDR_W-1:0] addr_t;                             // byte address
  typedef logic [`DC_WORD_W-1:0] word_t;
  typedef logic [`DC_WORD_W/8-1:0] strb_t;                           // one bit per byte lane
  typedef logic [`DC_ADDR_W-`DC_INDEX_W-`DC_OFFSET_W-1:0] tag_t;     // addr bits above the index
  typedef logic [`DC_INDEX_W-1:0] index_t;
  typedef logic [$clog2(`DC_BEATS)-1:0] word_sel_t;                  // word within a line
  typedef logic [$clog2(`DC_WAYS)-1:0] way_t;
  typedef logic [`DC_AGE_W-1:0] age_t;                               // 0 = most recently used
  typedef logic [`DC_BEATS*`DC_WORD_W-1:0] line_t;                   // word 0 in the low bits

  // one tag store entry
  typedef struct packed {
    logic valid;
    logic dirty;  // line differs from memory
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

/* rtl/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define DC_WAYS 6       // ways per set
`define DC_SETS 8       // sets in the cache
`define DC_INDEX_W 3    // log2 of the set count

// address split, byte offset covers one 32 byte line
`define DC_ADDR_W 32
`define DC_OFFSET_W 5
`define DC_WORD_W 32

// one line is one burst
`define DC_BEATS 8      // words per line and beats per burst
`define DC_AGE_W 3      // wide enough for ages 0..DC_WAYS-1

`endif

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// request FSM, line storage, byte merge and burst sequencing
module dcache_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req_valid,
  input  logic                       req_write,
  input  cache_geom_pkg::addr_t      req_addr,
  input  cache_geom_pkg::word_t      req_wdata,
  input  cache_geom_pkg::strb_t      req_wstrb,
  output logic                       req_ready,
  output logic                       rsp_valid,
  output cache_geom_pkg::word_t      rsp_data,
  input  logic                       rsp_ready,
  output logic                       rd_req_valid,
  output cache_geom_pkg::addr_t      rd_req_addr,
  input  logic                       rd_req_ready,
  input  logic                       rd_rsp_valid,
  input  cache_geom_pkg::word_t      rd_rsp_data,
  input  logic                       rd_rsp_last,
  output logic                       rd_rsp_ready,
  output logic                       wr_req_valid,
  output cache_geom_pkg::addr_t      wr_req_addr,
  input  logic                       wr_req_ready,
  output logic                       wr_data_valid,
  output cache_geom_pkg::word_t      wr_data,
  output logic                       wr_data_last,
  input  logic                       wr_data_ready,
  input  logic                       hit,
  input  cache_geom_pkg::way_t       hit_way,
  input  cache_geom_pkg::way_t       victim_way,
  input  logic                       victim_dirty,
  input  cache_geom_pkg::tag_t       victim_tag,
  output logic                       tag_we,
  output cache_geom_pkg::way_t       tag_way,
  output cache_geom_pkg::tag_entry_t tag_wentry,
  output logic                       touch,
  output cache_geom_pkg::way_t       touch_way
);

  localparam int LINE_W = $bits(cache_geom_pkg::line_t);

  mem_bus_pkg::ctrl_state_t  state, state_nxt;
  mem_bus_pkg::beat_cnt_t    beat_cnt;   // write-back beats sent
  cache_geom_pkg::index_t    index;
  cache_geom_pkg::tag_t      tag;
  cache_geom_pkg::word_sel_t word_sel;
  cache_geom_pkg::line_t     line_rdata [`DC_WAYS];
  cache_geom_pkg::line_t     hit_line, merged_line, line_wdata;
  cache_geom_pkg::line_t     line_buf;   // victim out / refill in, word 0 at the bottom
  cache_geom_pkg::word_t     old_word, new_word;
  cache_geom_pkg::way_t      line_way;
  logic line_we, write_hit, wr_beat, rd_beat, wb_done, fill_done;

  assign index    = req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign tag      = req_addr[`DC_ADDR_W-1 : `DC_OFFSET_W+`DC_INDEX_W];
  assign word_sel = req_addr[`DC_OFFSET_W-1 : 2];  // drop byte-in-word bits

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_line
    set_array #(
      .payload_t (cache_geom_pkg::line_t),
      .depth     (`DC_SETS)
    ) line_mem_inst (
      .clk   (clk),
      .rst   (rst),
      .we    (line_we && (line_way == cache_geom_pkg::way_t'(w))),
      .waddr (index),
      .wdata (line_wdata),
      .raddr (index),
      .rdata (line_rdata[w])
    );
  end

  assign hit_line = line_rdata[hit_way];
  assign old_word = hit_line[word_sel*`DC_WORD_W +: `DC_WORD_W];

  // strobed byte merge into the selected word
  always_comb begin
    new_word = old_word;
    for (int b = 0; b < `DC_WORD_W / 8; b++) begin
      if (req_wstrb[b]) new_word[b*8 +: 8] = req_wdata[b*8 +: 8];
    end
    merged_line = hit_line;
    merged_line[word_sel*`DC_WORD_W +: `DC_WORD_W] = new_word;
  end

  assign write_hit = (state == mem_bus_pkg::LOOKUP) && hit && req_write;
  assign wr_beat   = wr_data_valid && wr_data_ready;
  assign rd_beat   = rd_rsp_valid && rd_rsp_ready;
  assign wb_done   = wr_beat && wr_data_last;
  assign fill_done = rd_beat && rd_rsp_last;  // memory marks the eighth beat

  // line and tag writes, a write hit and a refill never overlap
  always_comb begin
    line_we    = 1'b0;
    line_way   = hit_way;
    line_wdata = merged_line;
    tag_we     = 1'b0;
    tag_way    = hit_way;
    tag_wentry = '{valid: 1'b1, dirty: 1'b1, tag: tag};
    if (write_hit) begin
      line_we = 1'b1;
      tag_we  = 1'b1;  // same tag, dirty now set
    end else if (fill_done) begin
      line_we          = 1'b1;
      line_way         = victim_way;
      line_wdata       = {rd_rsp_data, line_buf[LINE_W-1:`DC_WORD_W]};  // last beat goes on top
      tag_we           = 1'b1;
      tag_way          = victim_way;
      tag_wentry.dirty = 1'b0;  // fresh copy of memory
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      mem_bus_pkg::IDLE:        if (req_valid) state_nxt = mem_bus_pkg::LOOKUP;
      mem_bus_pkg::LOOKUP: begin
        if (hit) state_nxt = req_write ? mem_bus_pkg::IDLE : mem_bus_pkg::RESPOND;
        else     state_nxt = victim_dirty ? mem_bus_pkg::EVICT_REQ : mem_bus_pkg::REFILL_REQ;
      end
      mem_bus_pkg::RESPOND:     if (rsp_ready) state_nxt = mem_bus_pkg::IDLE;
      mem_bus_pkg::EVICT_REQ:   if (wr_req_ready) state_nxt = mem_bus_pkg::EVICT_DATA;
      mem_bus_pkg::EVICT_DATA:  if (wb_done) state_nxt = mem_bus_pkg::REFILL_REQ;
      mem_bus_pkg::REFILL_REQ:  if (rd_req_ready) state_nxt = mem_bus_pkg::REFILL_DATA;
      mem_bus_pkg::REFILL_DATA: if (fill_done) state_nxt = mem_bus_pkg::LOOKUP;  // retry hits
      default:                  state_nxt = mem_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= mem_bus_pkg::IDLE;
      beat_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == mem_bus_pkg::EVICT_REQ) beat_cnt <= '0;
      else if (wr_beat)                    beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if ((state == mem_bus_pkg::LOOKUP) && hit && !req_write) rsp_data <= old_word;
    if ((state == mem_bus_pkg::EVICT_REQ) && wr_req_ready) begin
      line_buf <= line_rdata[victim_way];  // snapshot before the refill overwrites it
    end else if (wr_beat) begin
      line_buf <= {{`DC_WORD_W{1'b0}}, line_buf[LINE_W-1:`DC_WORD_W]};
    end else if (rd_beat) begin
      line_buf <= {rd_rsp_data, line_buf[LINE_W-1:`DC_WORD_W]};
    end
  end

  assign req_ready = (state == mem_bus_pkg::LOOKUP) && hit;  // one cycle per request
  assign touch     = (state == mem_bus_pkg::LOOKUP) && hit;
  assign touch_way = hit_way;
  assign rsp_valid = (state == mem_bus_pkg::RESPOND);

  assign rd_req_valid  = (state == mem_bus_pkg::REFILL_REQ);
  assign rd_req_addr   = {req_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
  assign rd_rsp_ready  = (state == mem_bus_pkg::REFILL_DATA);
  assign wr_req_valid  = (state == mem_bus_pkg::EVICT_REQ);
  assign wr_req_addr   = {victim_tag, index, {`DC_OFFSET_W{1'b0}}};  // victim line base
  assign wr_data_valid = (state == mem_bus_pkg::EVICT_DATA);
  assign wr_data       = line_buf[`DC_WORD_W-1:0];
  assign wr_data_last  = wr_data_valid && (beat_cnt == mem_bus_pkg::beat_cnt_t'(`DC_BEATS - 1));

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// data cache top, lookup and lru run side by side and feed the controller
module dcache_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  logic                  req_write,    // 1 = store
  input  cache_geom_pkg::addr_t req_addr,
  input  cache_geom_pkg::word_t req_wdata,
  input  cache_geom_pkg::strb_t req_wstrb,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output cache_geom_pkg::word_t rsp_data,
  input  logic                  rsp_ready,
  output logic                  rd_req_valid,
  output cache_geom_pkg::addr_t rd_req_addr,  // line aligned, 8 beat burst
  input  logic                  rd_req_ready,
  input  logic                  rd_rsp_valid,
  input  cache_geom_pkg::word_t rd_rsp_data,
  input  logic                  rd_rsp_last,
  output logic                  rd_rsp_ready,
  output logic                  wr_req_valid,
  output cache_geom_pkg::addr_t wr_req_addr,  // line aligned, 8 beat burst
  input  logic                  wr_req_ready,
  output logic                  wr_data_valid,
  output cache_geom_pkg::word_t wr_data,
  output logic                  wr_data_last,
  input  logic                  wr_data_ready
);

  cache_geom_pkg::index_t     index;
  cache_geom_pkg::tag_t       tag;
  cache_geom_pkg::way_t       hit_way, victim_way, tag_way, touch_way;
  cache_geom_pkg::tag_t       victim_tag;
  cache_geom_pkg::tag_entry_t tag_wentry;
  logic hit, victim_dirty, tag_we, touch;

  assign index = req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign tag   = req_addr[`DC_ADDR_W-1 : `DC_OFFSET_W+`DC_INDEX_W];

  tag_lookup tag_lookup_inst (
    .clk(clk), .rst(rst), .index(index), .tag(tag), .victim_way(victim_way),
    .tag_we(tag_we), .tag_way(tag_way), .tag_wentry(tag_wentry),
    .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
  );

  lru_tracker lru_tracker_inst (
    .clk(clk), .rst(rst), .index(index),
    .touch(touch), .touch_way(touch_way), .victim_way(victim_way)
  );

  dcache_ctrl dcache_ctrl_inst (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
    .rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr), .rd_req_ready(rd_req_ready),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_data(rd_rsp_data), .rd_rsp_last(rd_rsp_last),
    .rd_rsp_ready(rd_rsp_ready),
    .wr_req_valid(wr_req_valid), .wr_req_addr(wr_req_addr), .wr_req_ready(wr_req_ready),
    .wr_data_valid(wr_data_valid), .wr_data(wr_data), .wr_data_last(wr_data_last),
    .wr_data_ready(wr_data_ready),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .tag_we(tag_we), .tag_way(tag_way), .tag_wentry(tag_wentry),
    .touch(touch), .touch_way(touch_way)
  );

endmodule

`default_nettype wire

/* rtl/lru_tracker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// per-set age counters, age DC_WAYS-1 marks the least recently used way
module lru_tracker (
  input  logic                   clk,
  input  logic                   rst,
  input  cache_geom_pkg::index_t index,
  input  logic                   touch,
  input  cache_geom_pkg::way_t   touch_way,
  output cache_geom_pkg::way_t   victim_way
);

  cache_geom_pkg::age_t age [`DC_SETS][`DC_WAYS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
          age[s][w] <= cache_geom_pkg::age_t'(w);  // way n starts at age n
        end
      end
    end else if (touch) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (cache_geom_pkg::way_t'(w) == touch_way) begin
          age[index][w] <= '0;  // touched way becomes youngest
        end else if (age[index][w] < age[index][touch_way]) begin
          age[index][w] <= age[index][w] + 1'b1;  // younger ones shift back one
        end
      end
    end
  end

  // ages in a set stay a permutation, so exactly one way matches
  always_comb begin
    victim_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (age[index][w] == cache_geom_pkg::age_t'(`DC_WAYS - 1)) begin
        victim_way = cache_geom_pkg::way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_bus_pkg.sv */
`default_nettype none
`include "dcache_cfg.svh"

// memory burst side and controller sequencing
package mem_bus_pkg;

  typedef logic [$clog2(`DC_BEATS):0] beat_cnt_t;  // counts 0..DC_BEATS

  typedef enum logic [2:0] {
    IDLE, LOOKUP, RESPOND, EVICT_REQ, EVICT_DATA, REFILL_REQ, REFILL_DATA
  } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/set_array.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// one entry per set, written at the edge and read combinationally
module set_array #(
  parameter type payload_t = logic,
  parameter int depth = `DC_SETS
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   we,
  input  cache_geom_pkg::index_t waddr,
  input  payload_t               wdata,
  input  cache_geom_pkg::index_t raddr,
  output payload_t               rdata
);

  payload_t mem [depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) mem[i] <= '0;  // zero entry = invalid tag
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];  // no read latency

endmodule

`default_nettype wire

/* rtl/tag_lookup.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// tag, valid and dirty storage for all ways plus the hit compare
module tag_lookup (
  input  logic                       clk,
  input  logic                       rst,
  input  cache_geom_pkg::index_t     index,
  input  cache_geom_pkg::tag_t       tag,
  input  cache_geom_pkg::way_t       victim_way,
  input  logic                       tag_we,
  input  cache_geom_pkg::way_t       tag_way,
  input  cache_geom_pkg::tag_entry_t tag_wentry,
  output logic                       hit,
  output cache_geom_pkg::way_t       hit_way,
  output logic                       victim_dirty,
  output cache_geom_pkg::tag_t       victim_tag
);

  cache_geom_pkg::tag_entry_t entry [`DC_WAYS];  // entries of the addressed set
  logic [`DC_WAYS-1:0] way_hit;

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    set_array #(
      .payload_t (cache_geom_pkg::tag_entry_t),
      .depth     (`DC_SETS)
    ) tag_mem_inst (
      .clk   (clk),
      .rst   (rst),
      .we    (tag_we && (tag_way == cache_geom_pkg::way_t'(w))),
      .waddr (index),
      .wdata (tag_wentry),
      .raddr (index),
      .rdata (entry[w])
    );
    assign way_hit[w] = entry[w].valid && (entry[w].tag == tag);
  end

  assign hit = |way_hit;

  // lowest way wins, though only one can match
  always_comb begin
    hit_way = '0;
    for (int w = `DC_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) hit_way = cache_geom_pkg::way_t'(w);
    end
  end

  // an invalid victim never needs a write-back
  assign victim_dirty = entry[victim_way].valid && entry[victim_way].dirty;
  assign victim_tag   = entry[victim_way].tag;  // high part of the write-back address

endmodule

`default_nettype wire

/* sim/dcache_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "dcache_cfg.svh"

// data cache testbench, table driven with a shadow memory and an lru model per set
module dcache_tb;

  localparam int MEM_WORDS = 64 * `DC_BEATS;  // 64 lines of backing memory
  localparam int MEM_AW    = $clog2(MEM_WORDS);
  localparam int TIMEOUT   = 500;             // cycles allowed for one request

  logic clk, rst;
  logic req_valid, req_write, req_ready, rsp_valid, rsp_ready;
  cache_geom_pkg::addr_t req_addr, rd_req_addr, wr_req_addr;
  cache_geom_pkg::word_t req_wdata, rsp_data, rd_rsp_data, wr_data;
  cache_geom_pkg::strb_t req_wstrb;
  logic rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_ready;
  logic wr_req_valid, wr_req_ready, wr_data_valid, wr_data_last, wr_data_ready;

  cache_geom_pkg::word_t mem  [MEM_WORDS];  // memory model contents
  cache_geom_pkg::word_t shad [MEM_WORDS];  // what the cpu must see
  logic                  mdl_valid [`DC_SETS][`DC_WAYS];
  logic                  mdl_dirty [`DC_SETS][`DC_WAYS];
  cache_geom_pkg::tag_t  mdl_tag   [`DC_SETS][`DC_WAYS];
  int unsigned           mdl_stamp [`DC_SETS][`DC_WAYS];  // time of last use
  int unsigned           now_stamp;
  int unsigned           n_checks;
  logic [31:0]           lfsr;

  // stimulus table, one entry per cpu request
  logic                  op_write [$];
  cache_geom_pkg::addr_t op_addr  [$];
  cache_geom_pkg::word_t op_wdata [$];
  cache_geom_pkg::strb_t op_wstrb [$];
  logic                  op_gaps  [$];  // random holes in ready and valid

  tb_clock #(.period_ns(40), .reset_cycles(2)) tb_clock_inst (.clk(clk), .rst(rst));

  dcache_top dcache_top_inst (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
    .req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_ready(rsp_ready),
    .rd_req_valid(rd_req_valid), .rd_req_addr(rd_req_addr), .rd_req_ready(rd_req_ready),
    .rd_rsp_valid(rd_rsp_valid), .rd_rsp_data(rd_rsp_data), .rd_rsp_last(rd_rsp_last),
    .rd_rsp_ready(rd_rsp_ready),
    .wr_req_valid(wr_req_valid), .wr_req_addr(wr_req_addr), .wr_req_ready(wr_req_ready),
    .wr_data_valid(wr_data_valid), .wr_data(wr_data), .wr_data_last(wr_data_last),
    .wr_data_ready(wr_data_ready)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input cache_geom_pkg::word_t got,
                            input cache_geom_pkg::word_t exp);
    n_checks++;
    if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input cache_geom_pkg::addr_t got,
                            input cache_geom_pkg::addr_t exp);
    n_checks++;
    if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input mem_bus_pkg::beat_cnt_t got,
                             input mem_bus_pkg::beat_cnt_t exp);
    n_checks++;
    if (got !== exp) report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic lfsr_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  task automatic pick_ready(input logic gaps, output logic r);
    if (gaps) lfsr_bit(r);  // one fresh bit per signal per cycle
    else r = 1'b1;
  endtask

  task automatic add_op(input logic wr, input cache_geom_pkg::addr_t a,
                        input cache_geom_pkg::word_t d, input cache_geom_pkg::strb_t s,
                        input logic g);
    op_write.push_back(wr);
    op_addr.push_back(a);
    op_wdata.push_back(d);
    op_wstrb.push_back(s);
    op_gaps.push_back(g);
  endtask

  // lru rule, an empty way first, else the one used longest ago
  function automatic int choose_slot(input int set);
    int slot;
    int unsigned best;
    slot = 0;
    best = 32'hffff_ffff;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (mdl_valid[set][w] && mdl_stamp[set][w] < best) begin
        best = mdl_stamp[set][w];
        slot = w;
      end
    end
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (!mdl_valid[set][w]) slot = w;
    end
    return slot;
  endfunction

  task automatic apply_op(input logic wr, input cache_geom_pkg::addr_t addr,
                          input cache_geom_pkg::word_t wdata, input cache_geom_pkg::strb_t wstrb,
                          input logic gaps);
    int set, slot, wi, rd_base, wb_base, cyc;
    int rd_reqs, wr_reqs, rd_beats, wr_beats;
    logic hit_exp, wb_exp, req_done, rsp_done, b;
    cache_geom_pkg::tag_t tag;
    cache_geom_pkg::addr_t rd_addr, wb_addr;
    cache_geom_pkg::word_t exp_rsp;

    set = int'(addr[`DC_OFFSET_W +: `DC_INDEX_W]);
    tag = addr[`DC_ADDR_W-1 : `DC_OFFSET_W+`DC_INDEX_W];
    wi  = int'(addr[MEM_AW+1:2]);  // word index into the memory model
    hit_exp = 1'b0;
    wb_exp  = 1'b0;
    slot    = 0;
    wb_addr = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (mdl_valid[set][w] && mdl_tag[set][w] == tag) begin
        hit_exp = 1'b1;
        slot    = w;
      end
    end
    if (!hit_exp) begin
      slot    = choose_slot(set);
      wb_exp  = mdl_valid[set][slot] && mdl_dirty[set][slot];  // only a dirty victim goes out
      wb_addr = {mdl_tag[set][slot], addr[`DC_OFFSET_W +: `DC_INDEX_W], {`DC_OFFSET_W{1'b0}}};
      mdl_valid[set][slot] = 1'b1;
      mdl_dirty[set][slot] = 1'b0;
      mdl_tag[set][slot]   = tag;
    end
    now_stamp++;
    mdl_stamp[set][slot] = now_stamp;
    if (wr) begin
      for (int i = 0; i < `DC_WORD_W / 8; i++) begin
        if (wstrb[i]) shad[wi][i*8 +: 8] = wdata[i*8 +: 8];
      end
      mdl_dirty[set][slot] = 1'b1;
    end
    exp_rsp = shad[wi];
    rd_addr = {addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    rd_base = int'(rd_addr[MEM_AW+1:2]);
    wb_base = int'(wb_addr[MEM_AW+1:2]);

    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wdata;
    req_wstrb = wstrb;
    req_done = 1'b0;
    rsp_done = 1'b0;
    rd_reqs  = 0;
    wr_reqs  = 0;
    rd_beats = 0;
    wr_beats = 0;
    cyc      = 0;
    while (!(req_done && (wr || rsp_done))) begin
      if (cyc == TIMEOUT) report_failure("timeout, the cache did not finish a request");
      @(negedge clk);  // values here are what the next rising edge takes
      if (rsp_valid) check_word("rsp_data", rsp_data, exp_rsp);  // also must hold while stalled
      if (rd_req_valid && rd_req_ready) begin
        check_addr("rd_req_addr", rd_req_addr, rd_addr);
        rd_reqs++;
      end
      if (rd_rsp_valid && rd_rsp_ready) rd_beats++;
      if (wr_req_valid && wr_req_ready) begin
        check_addr("wr_req_addr", wr_req_addr, wb_addr);
        wr_reqs++;
      end
      if (wr_data_valid && wr_data_ready) begin
        if (!wb_exp || wr_beats == `DC_BEATS) report_failure("unexpected write-back beat");
        check_word("wr_data", wr_data, shad[wb_base + wr_beats]);
        mem[wb_base + wr_beats] = wr_data;  // memory takes the victim line
        wr_beats++;
        // last flag on the eighth beat and on no other
        check_count("wr_data_last", mem_bus_pkg::beat_cnt_t'(wr_data_last),
                    mem_bus_pkg::beat_cnt_t'(wr_beats == `DC_BEATS));
      end
      if (req_valid && req_ready) req_done = 1'b1;
      if (rsp_valid && rsp_ready) rsp_done = 1'b1;
      @(posedge clk);
      #1;
      req_valid = !req_done;
      pick_ready(gaps, rd_req_ready);
      pick_ready(gaps, b);
      rd_rsp_valid = b && (rd_reqs != 0) && (rd_beats < `DC_BEATS);  // beats only after the request
      if (rd_beats < `DC_BEATS) rd_rsp_data = mem[rd_base + rd_beats];
      else rd_rsp_data = '0;
      rd_rsp_last = (rd_beats == `DC_BEATS - 1);
      pick_ready(gaps, wr_req_ready);
      pick_ready(gaps, wr_data_ready);
      pick_ready(gaps, rsp_ready);
      cyc++;
    end
    check_count("rd_req count", mem_bus_pkg::beat_cnt_t'(rd_reqs),
                mem_bus_pkg::beat_cnt_t'(hit_exp ? 0 : 1));
    check_count("rd_rsp beats", mem_bus_pkg::beat_cnt_t'(rd_beats),
                mem_bus_pkg::beat_cnt_t'(hit_exp ? 0 : `DC_BEATS));
    check_count("wr_req count", mem_bus_pkg::beat_cnt_t'(wr_reqs),
                mem_bus_pkg::beat_cnt_t'(wb_exp ? 1 : 0));
    check_count("wr_data beats", mem_bus_pkg::beat_cnt_t'(wr_beats),
                mem_bus_pkg::beat_cnt_t'(wb_exp ? `DC_BEATS : 0));
  endtask

  initial begin
    int cyc;
    req_valid     = 1'b0;
    req_write     = 1'b0;
    req_addr      = '0;
    req_wdata     = '0;
    req_wstrb     = '0;
    rsp_ready     = 1'b0;
    rd_req_ready  = 1'b0;
    rd_rsp_valid  = 1'b0;
    rd_rsp_data   = '0;
    rd_rsp_last   = 1'b0;
    wr_req_ready  = 1'b0;
    wr_data_ready = 1'b0;
    lfsr      = 32'he3d7;
    now_stamp = 0;
    n_checks  = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      // every word of the model differs, built from its byte address
      mem[i]  = 32'hc0de_0000 ^ (cache_geom_pkg::word_t'(i) << 2)
              ^ (cache_geom_pkg::word_t'(i) << 21);
      shad[i] = mem[i];
    end
    for (int s = 0; s < `DC_SETS; s++) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
        mdl_valid[s][w] = 1'b0;
        mdl_dirty[s][w] = 1'b0;
        mdl_tag[s][w]   = '0;
        mdl_stamp[s][w] = 0;
      end
    end

    //     write  address       data          strb  gaps
    add_op(1'b0, 32'h0000_0004, 32'h0,        4'h0, 1'b0);  // read miss in set 0
    add_op(1'b0, 32'h0000_0008, 32'h0,        4'h0, 1'b0);  // same line, hit
    add_op(1'b1, 32'h0000_0008, 32'h1122_3344, 4'h5, 1'b0); // partial write hit
    add_op(1'b0, 32'h0000_0008, 32'h0,        4'h0, 1'b0);  // merged word back
    add_op(1'b0, 32'h0000_0104, 32'h0,        4'h0, 1'b0);
    add_op(1'b0, 32'h0000_0204, 32'h0,        4'h0, 1'b0);
    add_op(1'b0, 32'h0000_0304, 32'h0,        4'h0, 1'b0);
    add_op(1'b0, 32'h0000_0404, 32'h0,        4'h0, 1'b0);
    add_op(1'b0, 32'h0000_0504, 32'h0,        4'h0, 1'b0);  // set 0 now full
    add_op(1'b0, 32'h0000_061c, 32'h0,        4'h0, 1'b0);  // seventh tag, dirty line out
    add_op(1'b0, 32'h0000_0008, 32'h0,        4'h0, 1'b0);  // refetch the written line
    add_op(1'b1, 32'h0000_0064, 32'hdead_beef, 4'hf, 1'b1); // write miss in set 3
    add_op(1'b1, 32'h0000_0164, 32'hcafe_0000, 4'hc, 1'b1);
    add_op(1'b0, 32'h0000_0064, 32'h0,        4'h0, 1'b1);
    add_op(1'b1, 32'h0000_0264, 32'h0bad_f00d, 4'h3, 1'b1);
    add_op(1'b1, 32'h0000_0364, 32'h1234_5678, 4'hf, 1'b1);
    add_op(1'b1, 32'h0000_0464, 32'h89ab_cdef, 4'h6, 1'b1);
    add_op(1'b1, 32'h0000_0564, 32'h55aa_55aa, 4'h9, 1'b1);
    add_op(1'b1, 32'h0000_0664, 32'ha5a5_a5a5, 4'hf, 1'b1); // dirty evictions from here on
    add_op(1'b1, 32'h0000_0764, 32'h0102_0304, 4'h8, 1'b1);
    add_op(1'b0, 32'h0000_0164, 32'h0,        4'h0, 1'b1);
    add_op(1'b0, 32'h0000_0064, 32'h0,        4'h0, 1'b1);
    add_op(1'b0, 32'h0000_061c, 32'h0,        4'h0, 1'b1);

    cyc = 0;
    while (rst !== 1'b0) begin
      if (cyc == 10) report_failure("reset was never released");
      @(posedge clk);
      cyc++;
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < op_write.size(); i++) begin
      apply_op(op_write[i], op_addr[i], op_wdata[i], op_wstrb[i], op_gaps[i]);
    end

    if (n_checks > 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_failure("no checks were run");
    end
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

// free running clock plus a reset held for the first few rising edges
module tb_clock #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;  // released just after an edge like every other input
  end

endmodule

`default_nettype wire
